// File: include/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

`define ID_XLEN      32
`define ID_REG_AW    5
`define ID_NREGS     32
`define ID_ALU_OP_W  12
`define ID_SRC1_W    3
`define ID_SRC2_W    4
`define ID_BR_W      8
`define ID_LINK_REG  5'd31

// operand select bit positions
`define ID_SRC1_RS     0
`define ID_SRC1_PC     1
`define ID_SRC1_SA     2
`define ID_SRC2_RT     0
`define ID_SRC2_IMM_SE 1
`define ID_SRC2_EIGHT  2
`define ID_SRC2_IMM_ZE 3

// branch kind bit positions
`define ID_BR_EQ   0
`define ID_BR_NE   1
`define ID_BR_GEZ  2
`define ID_BR_GTZ  3
`define ID_BR_LEZ  4
`define ID_BR_LTZ  5
`define ID_BR_JIMM 6
`define ID_BR_JREG 7

`define ID_OPC_SPECIAL 6'b00_0000
`define ID_OPC_REGIMM  6'b00_0001
`define ID_OPC_J       6'b00_0010
`define ID_OPC_JAL     6'b00_0011
`define ID_OPC_BEQ     6'b00_0100
`define ID_OPC_BNE     6'b00_0101
`define ID_OPC_BLEZ    6'b00_0110
`define ID_OPC_BGTZ    6'b00_0111
`define ID_OPC_ADDI    6'b00_1000
`define ID_OPC_ADDIU   6'b00_1001
`define ID_OPC_SLTI    6'b00_1010
`define ID_OPC_SLTIU   6'b00_1011
`define ID_OPC_ANDI    6'b00_1100
`define ID_OPC_ORI     6'b00_1101
`define ID_OPC_XORI    6'b00_1110
`define ID_OPC_LUI     6'b00_1111
`define ID_OPC_LW      6'b10_0011
`define ID_OPC_SW      6'b10_1011

`define ID_FN_SLL      6'b00_0000
`define ID_FN_SRL      6'b00_0010
`define ID_FN_SRA      6'b00_0011
`define ID_FN_SLLV     6'b00_0100
`define ID_FN_SRLV     6'b00_0110
`define ID_FN_SRAV     6'b00_0111
`define ID_FN_JR       6'b00_1000
`define ID_FN_JALR     6'b00_1001
`define ID_FN_ADD      6'b10_0000
`define ID_FN_ADDU     6'b10_0001
`define ID_FN_SUB      6'b10_0010
`define ID_FN_SUBU     6'b10_0011
`define ID_FN_AND      6'b10_0100
`define ID_FN_OR       6'b10_0101
`define ID_FN_XOR      6'b10_0110
`define ID_FN_NOR      6'b10_0111
`define ID_FN_SLT      6'b10_1010
`define ID_FN_SLTU     6'b10_1011

`define ID_RT_BLTZ     5'b00000
`define ID_RT_BGEZ     5'b00001
`define ID_RT_BLTZAL   5'b10000
`define ID_RT_BGEZAL   5'b10001

`endif

// File: rtl/id_pkg.sv
`default_nettype none

`include "id_defines.svh"

package id_pkg;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [`ID_REG_AW-1:0] rs;
        logic [`ID_REG_AW-1:0] rt;
        logic [`ID_REG_AW-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } rtype_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [`ID_REG_AW-1:0] rs;
        logic [`ID_REG_AW-1:0] rt;
        logic [15:0]           imm;
    } itype_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } jtype_t;

    // one instruction word, three views
    typedef union packed {
        rtype_t r;
        itype_t i;
        jtype_t j;
    } instr_t;

endpackage

`default_nettype wire

// File: rtl/id_stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_defines.svh"

module id_stage_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall_fetch,
    input  logic                stall_decode,
    input  logic                fetch_valid,
    input  logic [`ID_XLEN-1:0] fetch_pc,
    input  logic [`ID_XLEN-1:0] inst_rdata,
    output logic                id_valid,
    output logic [`ID_XLEN-1:0] id_pc,
    output id_pkg::instr_t      id_inst
);

    logic                hold_en;
    logic [`ID_XLEN-1:0] hold_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            hold_en  <= 1'b0;
        end else if (!stall_fetch) begin
            id_valid <= fetch_valid;
            id_pc    <= fetch_pc;
            hold_en  <= 1'b0;
        end else if (!stall_decode) begin
            // fetch held alone, push a bubble
            id_valid <= 1'b0;
            id_pc    <= '0;
            hold_en  <= 1'b0;
        end else begin
            hold_en  <= 1'b1;
        end
    end

    // memory output moves on during a stall, keep the first copy
    always_ff @(posedge clk) begin
        if (stall_fetch && stall_decode && !hold_en) begin
            hold_inst <= inst_rdata;
        end
    end

    assign id_inst = hold_en ? hold_inst : inst_rdata;

endmodule

`default_nettype wire

// File: rtl/regfile_bypass.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_defines.svh"

module regfile_bypass (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ID_REG_AW-1:0] rs_addr,
    input  logic [`ID_REG_AW-1:0] rt_addr,
    input  logic                  wb_we,
    input  logic [`ID_REG_AW-1:0] wb_waddr,
    input  logic [`ID_XLEN-1:0]   wb_wdata,
    input  logic                  ex_we,
    input  logic [`ID_REG_AW-1:0] ex_waddr,
    input  logic [`ID_XLEN-1:0]   ex_wdata,
    input  logic                  mem_we,
    input  logic [`ID_REG_AW-1:0] mem_waddr,
    input  logic [`ID_XLEN-1:0]   mem_wdata,
    output logic [`ID_XLEN-1:0]   rs_data,
    output logic [`ID_XLEN-1:0]   rt_data
);

    logic [`ID_XLEN-1:0] regs [`ID_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ID_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    // youngest producer wins
    function automatic logic [`ID_XLEN-1:0] read_port(input logic [`ID_REG_AW-1:0] addr);
        logic [`ID_XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (ex_we && ex_waddr == addr) begin
            data = ex_wdata;
        end else if (mem_we && mem_waddr == addr) begin
            data = mem_wdata;
        end else if (wb_we && wb_waddr == addr) begin
            data = wb_wdata;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_defines.svh"

module inst_decoder (
    input  logic                    id_valid,
    input  id_pkg::instr_t          id_inst,
    input  logic                    ex_is_load,
    input  logic [`ID_REG_AW-1:0]   ex_waddr,
    output logic [`ID_REG_AW-1:0]   rs_addr,
    output logic [`ID_REG_AW-1:0]   rt_addr,
    output logic [`ID_ALU_OP_W-1:0] alu_op,
    output logic [`ID_SRC1_W-1:0]   src1_sel,
    output logic [`ID_SRC2_W-1:0]   src2_sel,
    output logic                    dmem_en,
    output logic                    dmem_we,
    output logic                    rf_we,
    output logic [`ID_REG_AW-1:0]   rf_waddr,
    output logic [`ID_BR_W-1:0]     br_kind,
    output logic                    stall_req
);

    logic [5:0] op, fn;
    logic special, regimm, sa_zero, rs_zero, rt_zero, rd_zero;
    logic inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_jr, inst_jalr, inst_j, inst_jal;
    logic inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_blez, inst_bgtz;
    logic inst_bltz, inst_bgez, inst_bltzal, inst_bgezal;
    logic r_alu, i_alu, link31, uses_rs, uses_rt;

    assign op      = id_inst.r.opcode;
    assign fn      = id_inst.r.funct;
    assign special = (op == `ID_OPC_SPECIAL);
    assign regimm  = (op == `ID_OPC_REGIMM);
    assign sa_zero = (id_inst.r.shamt == '0);
    assign rs_zero = (id_inst.r.rs == '0);
    assign rt_zero = (id_inst.i.rt == '0);
    assign rd_zero = (id_inst.r.rd == '0);

    assign inst_add    = special & sa_zero & (fn == `ID_FN_ADD);
    assign inst_addu   = special & sa_zero & (fn == `ID_FN_ADDU);
    assign inst_sub    = special & sa_zero & (fn == `ID_FN_SUB);
    assign inst_subu   = special & sa_zero & (fn == `ID_FN_SUBU);
    assign inst_slt    = special & sa_zero & (fn == `ID_FN_SLT);
    assign inst_sltu   = special & sa_zero & (fn == `ID_FN_SLTU);
    assign inst_and    = special & sa_zero & (fn == `ID_FN_AND);
    assign inst_or     = special & sa_zero & (fn == `ID_FN_OR);
    assign inst_xor    = special & sa_zero & (fn == `ID_FN_XOR);
    assign inst_nor    = special & sa_zero & (fn == `ID_FN_NOR);
    assign inst_sll    = special & rs_zero & (fn == `ID_FN_SLL);
    assign inst_srl    = special & rs_zero & (fn == `ID_FN_SRL);
    assign inst_sra    = special & rs_zero & (fn == `ID_FN_SRA);
    assign inst_sllv   = special & sa_zero & (fn == `ID_FN_SLLV);
    assign inst_srlv   = special & sa_zero & (fn == `ID_FN_SRLV);
    assign inst_srav   = special & sa_zero & (fn == `ID_FN_SRAV);
    assign inst_jr     = special & rt_zero & rd_zero & sa_zero & (fn == `ID_FN_JR);
    assign inst_jalr   = special & rt_zero & sa_zero & (fn == `ID_FN_JALR);
    assign inst_j      = (op == `ID_OPC_J);
    assign inst_jal    = (op == `ID_OPC_JAL);
    assign inst_addi   = (op == `ID_OPC_ADDI);
    assign inst_addiu  = (op == `ID_OPC_ADDIU);
    assign inst_slti   = (op == `ID_OPC_SLTI);
    assign inst_sltiu  = (op == `ID_OPC_SLTIU);
    assign inst_andi   = (op == `ID_OPC_ANDI);
    assign inst_ori    = (op == `ID_OPC_ORI);
    assign inst_xori   = (op == `ID_OPC_XORI);
    assign inst_lui    = (op == `ID_OPC_LUI);
    assign inst_lw     = (op == `ID_OPC_LW);
    assign inst_sw     = (op == `ID_OPC_SW);
    assign inst_beq    = (op == `ID_OPC_BEQ);
    assign inst_bne    = (op == `ID_OPC_BNE);
    assign inst_blez   = (op == `ID_OPC_BLEZ) & rt_zero;
    assign inst_bgtz   = (op == `ID_OPC_BGTZ) & rt_zero;
    assign inst_bltz   = regimm & (id_inst.i.rt == `ID_RT_BLTZ);
    assign inst_bgez   = regimm & (id_inst.i.rt == `ID_RT_BGEZ);
    assign inst_bltzal = regimm & (id_inst.i.rt == `ID_RT_BLTZAL);
    assign inst_bgezal = regimm & (id_inst.i.rt == `ID_RT_BGEZAL);

    // register-register ALU ops, shifts included
    assign r_alu = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
                 | inst_and | inst_or | inst_xor | inst_nor
                 | inst_sll | inst_srl | inst_sra | inst_sllv | inst_srlv | inst_srav;
    assign i_alu = inst_addi | inst_addiu | inst_slti | inst_sltiu
                 | inst_andi | inst_ori | inst_xori | inst_lui;
    assign link31 = inst_jal | inst_bltzal | inst_bgezal;

    assign src1_sel[`ID_SRC1_RS] = (r_alu & ~(inst_sll | inst_srl | inst_sra))
                                 | (i_alu & ~inst_lui) | inst_lw | inst_sw;
    assign src1_sel[`ID_SRC1_PC] = link31 | inst_jalr;
    assign src1_sel[`ID_SRC1_SA] = inst_sll | inst_srl | inst_sra;

    assign src2_sel[`ID_SRC2_RT]     = r_alu;
    assign src2_sel[`ID_SRC2_IMM_SE] = inst_addi | inst_addiu | inst_slti | inst_sltiu
                                     | inst_lui | inst_lw | inst_sw;
    // link value is pc+8
    assign src2_sel[`ID_SRC2_EIGHT]  = link31 | inst_jalr;
    assign src2_sel[`ID_SRC2_IMM_ZE] = inst_andi | inst_ori | inst_xori;

    assign alu_op = {
        inst_add | inst_addu | inst_addi | inst_addiu | inst_lw | inst_sw | link31 | inst_jalr,
        inst_sub | inst_subu,
        inst_slt | inst_slti,
        inst_sltu | inst_sltiu,
        inst_and | inst_andi,
        inst_nor,
        inst_or | inst_ori,
        inst_xor | inst_xori,
        inst_sll | inst_sllv,
        inst_srl | inst_srlv,
        inst_sra | inst_srav,
        inst_lui
    };

    assign dmem_en  = id_valid & (inst_lw | inst_sw);
    assign dmem_we  = id_valid & inst_sw;
    assign rf_we    = id_valid & (r_alu | i_alu | inst_lw | link31 | inst_jalr);
    assign rf_waddr = link31 ? `ID_LINK_REG :
                      (r_alu | inst_jalr) ? id_inst.r.rd : id_inst.i.rt;

    assign br_kind[`ID_BR_EQ]   = id_valid & inst_beq;
    assign br_kind[`ID_BR_NE]   = id_valid & inst_bne;
    assign br_kind[`ID_BR_GEZ]  = id_valid & (inst_bgez | inst_bgezal);
    assign br_kind[`ID_BR_GTZ]  = id_valid & inst_bgtz;
    assign br_kind[`ID_BR_LEZ]  = id_valid & inst_blez;
    assign br_kind[`ID_BR_LTZ]  = id_valid & (inst_bltz | inst_bltzal);
    assign br_kind[`ID_BR_JIMM] = id_valid & (inst_j | inst_jal);
    assign br_kind[`ID_BR_JREG] = id_valid & (inst_jr | inst_jalr);

    assign rs_addr = id_inst.r.rs;
    assign rt_addr = id_inst.r.rt;

    // only sources that are really read can cause a load-use hazard
    assign uses_rs = src1_sel[`ID_SRC1_RS] | inst_beq | inst_bne | inst_blez | inst_bgtz
                   | inst_bltz | inst_bgez | inst_bltzal | inst_bgezal | inst_jr | inst_jalr;
    assign uses_rt = r_alu | inst_sw | inst_beq | inst_bne;

    assign stall_req = id_valid & ex_is_load & (ex_waddr != '0)
                     & ((uses_rs & (rs_addr == ex_waddr)) | (uses_rt & (rt_addr == ex_waddr)));

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_defines.svh"

module branch_unit (
    input  logic [`ID_XLEN-1:0] id_pc,
    input  id_pkg::instr_t      id_inst,
    input  logic [`ID_BR_W-1:0] br_kind,
    input  logic [`ID_XLEN-1:0] rs_data,
    input  logic [`ID_XLEN-1:0] rt_data,
    output logic                br_taken,
    output logic [`ID_XLEN-1:0] br_target
);

    logic [`ID_XLEN-1:0] pc_plus4;
    logic [`ID_XLEN-1:0] br_offset;
    logic [`ID_BR_W-1:0] cond;
    logic                rs_eq_rt, rs_neg, rs_is_zero;

    assign pc_plus4  = id_pc + `ID_XLEN'd4;
    assign br_offset = {{(`ID_XLEN-18){id_inst.i.imm[15]}}, id_inst.i.imm, 2'b00};

    assign rs_eq_rt   = (rs_data == rt_data);
    assign rs_neg     = rs_data[`ID_XLEN-1];
    assign rs_is_zero = (rs_data == '0);

    always_comb begin
        cond                = '0;
        cond[`ID_BR_EQ]     = rs_eq_rt;
        cond[`ID_BR_NE]     = !rs_eq_rt;
        cond[`ID_BR_GEZ]    = !rs_neg;
        cond[`ID_BR_GTZ]    = !rs_neg && !rs_is_zero;
        cond[`ID_BR_LEZ]    = rs_neg || rs_is_zero;
        cond[`ID_BR_LTZ]    = rs_neg;
        // jumps are unconditional
        cond[`ID_BR_JIMM]   = 1'b1;
        cond[`ID_BR_JREG]   = 1'b1;
    end

    assign br_taken = |(br_kind & cond);

    always_comb begin
        if (br_kind[`ID_BR_JREG]) begin
            br_target = rs_data;
        end else if (br_kind[`ID_BR_JIMM]) begin
            br_target = {pc_plus4[`ID_XLEN-1:28], id_inst.j.index, 2'b00};
        end else begin
            br_target = pc_plus4 + br_offset;
        end
    end

endmodule

`default_nettype wire

// File: rtl/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_defines.svh"

module id_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_valid,
    input  logic [`ID_XLEN-1:0]     fetch_pc,
    input  logic [`ID_XLEN-1:0]     inst_rdata,
    input  logic                    stall_fetch,
    input  logic                    stall_decode,
    input  logic                    wb_we,
    input  logic [`ID_REG_AW-1:0]   wb_waddr,
    input  logic [`ID_XLEN-1:0]     wb_wdata,
    input  logic                    ex_we,
    input  logic [`ID_REG_AW-1:0]   ex_waddr,
    input  logic [`ID_XLEN-1:0]     ex_wdata,
    input  logic                    ex_is_load,
    input  logic                    mem_we,
    input  logic [`ID_REG_AW-1:0]   mem_waddr,
    input  logic [`ID_XLEN-1:0]     mem_wdata,
    output logic                    id_valid,
    output logic [`ID_XLEN-1:0]     id_pc,
    output id_pkg::instr_t          id_inst,
    output logic [`ID_ALU_OP_W-1:0] alu_op,
    output logic [`ID_SRC1_W-1:0]   src1_sel,
    output logic [`ID_SRC2_W-1:0]   src2_sel,
    output logic                    dmem_en,
    output logic                    dmem_we,
    output logic                    rf_we,
    output logic [`ID_REG_AW-1:0]   rf_waddr,
    output logic [`ID_XLEN-1:0]     rs_data,
    output logic [`ID_XLEN-1:0]     rt_data,
    output logic                    br_taken,
    output logic [`ID_XLEN-1:0]     br_target,
    output logic                    stall_req
);

    logic [`ID_REG_AW-1:0] rs_addr;
    logic [`ID_REG_AW-1:0] rt_addr;
    logic [`ID_BR_W-1:0]   br_kind;

    id_stage_reg stage_reg_i (
        .clk          (clk),
        .rst          (rst),
        .stall_fetch  (stall_fetch),
        .stall_decode (stall_decode),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .inst_rdata   (inst_rdata),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_inst      (id_inst)
    );

    regfile_bypass regfile_i (
        .clk       (clk),
        .rst       (rst),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .wb_we     (wb_we),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata),
        .ex_we     (ex_we),
        .ex_waddr  (ex_waddr),
        .ex_wdata  (ex_wdata),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    inst_decoder decoder_i (
        .id_valid   (id_valid),
        .id_inst    (id_inst),
        .ex_is_load (ex_is_load),
        .ex_waddr   (ex_waddr),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .alu_op     (alu_op),
        .src1_sel   (src1_sel),
        .src2_sel   (src2_sel),
        .dmem_en    (dmem_en),
        .dmem_we    (dmem_we),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .br_kind    (br_kind),
        .stall_req  (stall_req)
    );

    branch_unit branch_i (
        .id_pc     (id_pc),
        .id_inst   (id_inst),
        .br_kind   (br_kind),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

`default_nettype wire

// File: dv/id_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_defines.svh"

module id_tb;

    localparam int NUM_CYCLES = 4000;
    // add is the top alu_op bit
    localparam int A_ADD = 11, A_SUB = 10, A_SLT = 9, A_SLTU = 8, A_AND = 7, A_NOR = 6;
    localparam int A_OR = 5, A_XOR = 4, A_SLL = 3, A_SRL = 2, A_SRA = 1, A_LUI = 0;
    localparam logic [2:0] S1_RS = 3'b001, S1_PC = 3'b010, S1_SA = 3'b100;
    localparam logic [3:0] S2_RT = 4'b0001, S2_SE = 4'b0010, S2_8 = 4'b0100, S2_ZE = 4'b1000;
    localparam logic [5:0] R_FN [18] = '{`ID_FN_SLL, `ID_FN_SRL, `ID_FN_SRA, `ID_FN_SLLV,
        `ID_FN_SRLV, `ID_FN_SRAV, `ID_FN_JR, `ID_FN_JALR, `ID_FN_ADD, `ID_FN_ADDU, `ID_FN_SUB,
        `ID_FN_SUBU, `ID_FN_AND, `ID_FN_OR, `ID_FN_XOR, `ID_FN_NOR, `ID_FN_SLT, `ID_FN_SLTU};
    localparam logic [5:0] I_OP [16] = '{`ID_OPC_J, `ID_OPC_JAL, `ID_OPC_BEQ, `ID_OPC_BNE,
        `ID_OPC_BLEZ, `ID_OPC_BGTZ, `ID_OPC_ADDI, `ID_OPC_ADDIU, `ID_OPC_SLTI, `ID_OPC_SLTIU,
        `ID_OPC_ANDI, `ID_OPC_ORI, `ID_OPC_XORI, `ID_OPC_LUI, `ID_OPC_LW, `ID_OPC_SW};
    localparam logic [4:0] RI_RT [4] = '{`ID_RT_BLTZ, `ID_RT_BGEZ, `ID_RT_BLTZAL, `ID_RT_BGEZAL};

    logic clk, rst, fetch_valid, stall_fetch, stall_decode;
    logic [`ID_XLEN-1:0] fetch_pc, inst_rdata, wb_wdata, ex_wdata, mem_wdata;
    logic wb_we, ex_we, ex_is_load, mem_we;
    logic [`ID_REG_AW-1:0] wb_waddr, ex_waddr, mem_waddr, rf_waddr;
    logic id_valid, dmem_en, dmem_we, rf_we, br_taken, stall_req;
    logic [`ID_XLEN-1:0] id_pc, rs_data, rt_data, br_target;
    id_pkg::instr_t id_inst;
    logic [`ID_ALU_OP_W-1:0] alu_op;
    logic [`ID_SRC1_W-1:0] src1_sel;
    logic [`ID_SRC2_W-1:0] src2_sel;

    // reference state
    logic [`ID_XLEN-1:0] shadow [`ID_NREGS];
    logic m_valid, m_hold, m_pc_ok;
    logic [`ID_XLEN-1:0] m_pc, m_held;
    logic [`ID_ALU_OP_W-1:0] e_alu;
    logic [`ID_SRC1_W-1:0] e_s1;
    logic [`ID_SRC2_W-1:0] e_s2;
    logic e_dm, e_dw, e_rfwe, e_urs, e_urt, e_isbr, e_taken, e_stall;
    logic [`ID_REG_AW-1:0] e_waddr;
    logic [`ID_XLEN-1:0] e_target;
    int cyc;

    id_stage dut_i (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_ctrl(input string name, input logic [`ID_ALU_OP_W-1:0] exp,
                              input logic [`ID_ALU_OP_W-1:0] act);
        if (exp !== act)
            report_failure($sformatf("Error %s cycle %0d expected %h actual %h",
                                     name, cyc, exp, act));
    endtask

    task automatic check_word(input string name, input logic [`ID_XLEN-1:0] exp,
                              input logic [`ID_XLEN-1:0] act);
        if (exp !== act)
            report_failure($sformatf("Error %s cycle %0d expected %h actual %h",
                                     name, cyc, exp, act));
    endtask

    task automatic check_inst(input string name, input id_pkg::instr_t exp,
                              input id_pkg::instr_t act);
        if (exp !== act)
            report_failure($sformatf("Error %s cycle %0d expected %h actual %h",
                                     name, cyc, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            report_failure($sformatf("Error %s cycle %0d expected %b actual %b",
                                     name, cyc, exp, act));
    endtask

    // random kept instruction with its must-be-zero fields cleared
    function automatic logic [31:0] gen_inst();
        logic [31:0] r1, r2;
        logic [5:0] opc, fn;
        logic [4:0] rs, rt, rd, sa;
        int k;
        r1 = $urandom;
        r2 = $urandom;
        rs = r1[4:0];
        rt = r1[9:5];
        rd = r1[14:10];
        sa = r1[19:15];
        fn = r1[25:20];
        k = r2 % 38;
        opc = `ID_OPC_SPECIAL;
        if (k < 18) begin
            fn = R_FN[k];
            if (k < 3) rs = '0;
            else sa = '0;
            if (k == 6 || k == 7) rt = '0;
            if (k == 6) rd = '0;
        end else if (k < 34) begin
            opc = I_OP[k-18];
            if (k == 22 || k == 23) rt = '0;
        end else begin
            opc = `ID_OPC_REGIMM;
            rt = RI_RT[k-34];
        end
        return {opc, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [`ID_XLEN-1:0] read_model(input logic [`ID_REG_AW-1:0] addr);
        if (addr == '0) return '0;
        if (ex_we && ex_waddr == addr) return ex_wdata;
        if (mem_we && mem_waddr == addr) return mem_wdata;
        if (wb_we && wb_waddr == addr) return wb_wdata;
        return shadow[addr];
    endfunction

    task automatic set_link();
        e_rfwe = 1'b1;
        e_waddr = `ID_LINK_REG;
        e_s1 = S1_PC;
        e_s2 = S2_8;
        e_alu[A_ADD] = 1'b1;
    endtask

    task automatic compute_expected(input logic [31:0] w);
        logic [5:0] opc, fn;
        logic [4:0] rs, rt;
        logic [31:0] a, b, pc4, boff;
        opc = w[31:26];
        fn = w[5:0];
        rs = w[25:21];
        rt = w[20:16];
        a = read_model(rs);
        b = read_model(rt);
        pc4 = m_pc + 32'd4;
        boff = {{14{w[15]}}, w[15:0], 2'b00};
        e_alu = '0;
        e_s1 = '0;
        e_s2 = '0;
        e_dm = 0;
        e_dw = 0;
        e_rfwe = 0;
        e_waddr = w[20:16];
        e_urs = 0;
        e_urt = 0;
        e_isbr = 0;
        e_taken = 0;
        e_target = pc4 + boff;
        case (opc)
            `ID_OPC_SPECIAL: begin
                e_rfwe = 1'b1;
                e_waddr = w[15:11];
                if (fn == `ID_FN_JR || fn == `ID_FN_JALR) begin
                    e_isbr = 1;
                    e_taken = 1;
                    e_target = a;
                    e_urs = 1;
                    e_rfwe = (fn == `ID_FN_JALR);
                    if (fn == `ID_FN_JALR) begin
                        e_s1 = S1_PC;
                        e_s2 = S2_8;
                        e_alu[A_ADD] = 1;
                    end
                end else begin
                    e_s2 = S2_RT;
                    e_urt = 1;
                    e_urs = !(fn == `ID_FN_SLL || fn == `ID_FN_SRL || fn == `ID_FN_SRA);
                    e_s1 = e_urs ? S1_RS : S1_SA;
                    case (fn)
                        `ID_FN_ADD, `ID_FN_ADDU: e_alu[A_ADD] = 1;
                        `ID_FN_SUB, `ID_FN_SUBU: e_alu[A_SUB] = 1;
                        `ID_FN_SLT:  e_alu[A_SLT] = 1;
                        `ID_FN_SLTU: e_alu[A_SLTU] = 1;
                        `ID_FN_AND:  e_alu[A_AND] = 1;
                        `ID_FN_NOR:  e_alu[A_NOR] = 1;
                        `ID_FN_OR:   e_alu[A_OR] = 1;
                        `ID_FN_XOR:  e_alu[A_XOR] = 1;
                        `ID_FN_SLL, `ID_FN_SLLV: e_alu[A_SLL] = 1;
                        `ID_FN_SRL, `ID_FN_SRLV: e_alu[A_SRL] = 1;
                        default: e_alu[A_SRA] = 1;
                    endcase
                end
            end
            `ID_OPC_J, `ID_OPC_JAL: begin
                e_isbr = 1;
                e_taken = 1;
                e_target = {pc4[31:28], w[25:0], 2'b00};
                if (opc == `ID_OPC_JAL) set_link();
            end
            `ID_OPC_BEQ, `ID_OPC_BNE: begin
                e_isbr = 1;
                e_urs = 1;
                e_urt = 1;
                e_taken = (opc == `ID_OPC_BEQ) ? (a == b) : (a != b);
            end
            `ID_OPC_BLEZ: begin
                e_isbr = 1;
                e_urs = 1;
                e_taken = $signed(a) <= 0;
            end
            `ID_OPC_BGTZ: begin
                e_isbr = 1;
                e_urs = 1;
                e_taken = $signed(a) > 0;
            end
            `ID_OPC_REGIMM: begin
                e_isbr = 1;
                e_urs = 1;
                e_taken = rt[0] ? ($signed(a) >= 0) : ($signed(a) < 0);
                if (rt[4]) set_link();
            end
            `ID_OPC_LW, `ID_OPC_SW: begin
                e_dm = 1;
                e_dw = (opc == `ID_OPC_SW);
                e_rfwe = !e_dw;
                e_urs = 1;
                e_urt = e_dw;
                e_s1 = S1_RS;
                e_s2 = S2_SE;
                e_alu[A_ADD] = 1;
            end
            default: begin
                // I-type ALU group
                e_rfwe = 1;
                e_urs = (opc != `ID_OPC_LUI);
                e_s1 = e_urs ? S1_RS : 3'b000;
                e_s2 = (opc >= `ID_OPC_ANDI && opc <= `ID_OPC_XORI) ? S2_ZE : S2_SE;
                case (opc)
                    `ID_OPC_ADDI, `ID_OPC_ADDIU: e_alu[A_ADD] = 1;
                    `ID_OPC_SLTI:  e_alu[A_SLT] = 1;
                    `ID_OPC_SLTIU: e_alu[A_SLTU] = 1;
                    `ID_OPC_ANDI:  e_alu[A_AND] = 1;
                    `ID_OPC_ORI:   e_alu[A_OR] = 1;
                    `ID_OPC_XORI:  e_alu[A_XOR] = 1;
                    default:       e_alu[A_LUI] = 1;
                endcase
            end
        endcase
        e_stall = m_valid && ex_is_load && ex_waddr != '0
                  && ((e_urs && rs == ex_waddr) || (e_urt && rt == ex_waddr));
        if (!m_valid) begin
            e_rfwe = 0;
            e_dm = 0;
            e_dw = 0;
            e_taken = 0;
        end
    endtask

    // stage register and register file at the clock edge
    task automatic model_clock();
        if (rst) begin
            m_valid = 1'b0;
            m_hold = 1'b0;
            for (int i = 0; i < `ID_NREGS; i++) shadow[i] = '0;
        end else begin
            if (wb_we && wb_waddr != '0) shadow[wb_waddr] = wb_wdata;
            if (!stall_fetch || !stall_decode) begin
                m_valid = !stall_fetch && fetch_valid;
                m_pc = stall_fetch ? '0 : fetch_pc;
                m_hold = 1'b0;
                m_pc_ok = 1'b1;
            end else begin
                if (!m_hold) m_held = inst_rdata;
                m_hold = 1'b1;
            end
        end
    endtask

    task automatic drive_random();
        logic [31:0] r, p;
        logic [31:0] cur;
        logic [4:0] focus;
        r = $urandom;
        p = $urandom;
        fetch_valid = r[0] | r[1];
        stall_fetch = (r[3:2] == 2'b00);
        stall_decode = stall_fetch & r[4];
        fetch_pc = {p[31:2], 2'b00};
        inst_rdata = gen_inst();
        cur = m_hold ? m_held : inst_rdata;
        // steer producers onto a source register to hit forwarding and hazards
        focus = r[5] ? cur[25:21] : cur[20:16];
        ex_we = r[6];
        ex_is_load = r[7];
        ex_waddr = r[8] ? focus : r[13:9];
        mem_we = r[14];
        mem_waddr = r[15] ? focus : r[20:16];
        wb_we = r[21] | r[22];
        wb_waddr = r[23] ? focus : r[28:24];
        ex_wdata = $urandom;
        mem_wdata = $urandom;
        wb_wdata = $urandom;
    endtask

    task automatic check_outputs(input string t);
        logic [31:0] w;
        w = m_hold ? m_held : inst_rdata;
        compute_expected(w);
        check_bit({t, " id_valid"}, m_valid, id_valid);
        if (m_pc_ok) check_word({t, " id_pc"}, m_pc, id_pc);
        check_inst({t, " id_inst"}, w, id_inst);
        check_word({t, " rs_data"}, read_model(w[25:21]), rs_data);
        check_word({t, " rt_data"}, read_model(w[20:16]), rt_data);
        check_bit({t, " rf_we"}, e_rfwe, rf_we);
        check_bit({t, " dmem_en"}, e_dm, dmem_en);
        check_bit({t, " dmem_we"}, e_dw, dmem_we);
        check_bit({t, " br_taken"}, e_taken, br_taken);
        check_bit({t, " stall_req"}, e_stall, stall_req);
        if (m_valid) begin
            check_ctrl({t, " alu_op"}, e_alu, alu_op);
            check_ctrl({t, " src1_sel"}, 12'(e_s1), 12'(src1_sel));
            check_ctrl({t, " src2_sel"}, 12'(e_s2), 12'(src2_sel));
            if (e_rfwe) check_ctrl({t, " rf_waddr"}, 12'(e_waddr), 12'(rf_waddr));
            if (e_isbr) check_word({t, " br_target"}, e_target, br_target);
        end
    endtask

    initial begin
        void'($urandom(14));
        rst = 1'b1;
        fetch_valid = 0;
        fetch_pc = '0;
        inst_rdata = '0;
        stall_fetch = 0;
        stall_decode = 0;
        wb_we = 0;
        wb_waddr = '0;
        wb_wdata = '0;
        ex_we = 0;
        ex_waddr = '0;
        ex_wdata = '0;
        ex_is_load = 0;
        mem_we = 0;
        mem_waddr = '0;
        mem_wdata = '0;
        m_valid = 0;
        m_hold = 0;
        m_pc_ok = 0;
        m_pc = '0;
        m_held = '0;
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            model_clock();
            #1;
            if (cyc == 2) rst = 1'b0;
            if (cyc > 2) drive_random();
            #4;
            check_outputs(cyc < 4 ? "reset" : "random");
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/id_pkg.sv
rtl/id_stage_reg.sv
rtl/regfile_bypass.sv
rtl/inst_decoder.sv
rtl/branch_unit.sv
rtl/id_stage.sv
dv/id_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= id_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= all.f
VFLAGS    ?= --binary -j 0

SRCS := $(filter-out +incdir%,$(shell cat $(FLIST)))
HDRS := include/id_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
